// ==== src/lsu_pkg.sv ====
// RV32 load/store codes as given by the execute stage; data path fixed at 32 bits
`default_nettype none

package lsu_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int BYTE_W = 8;
	localparam int HALF_W = 16;
	localparam int STRB_W = DATA_W / BYTE_W;

	typedef logic [DATA_W-1:0] data_t;
	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [STRB_W-1:0] strb_t;
	typedef logic [$clog2(STRB_W)-1:0] offset_t;
	typedef logic [4:0] reg_idx_t;

	// any nonzero code is a load
	typedef logic [2:0] load_type_t;
	localparam load_type_t LOAD_NONE = 3'd0;
	localparam load_type_t LOAD_LB   = 3'd1;
	localparam load_type_t LOAD_LH   = 3'd2;
	localparam load_type_t LOAD_LW   = 3'd3;
	localparam load_type_t LOAD_LBU  = 3'd4;
	localparam load_type_t LOAD_LHU  = 3'd5;

	typedef logic [1:0] store_type_t;
	localparam store_type_t STORE_NONE = 2'd0;
	localparam store_type_t STORE_SB   = 2'd1;
	localparam store_type_t STORE_SH   = 2'd2;
	localparam store_type_t STORE_SW   = 2'd3;

	// controller FSM
	typedef enum logic [1:0] {
		LSU_IDLE,
		LSU_ADDR,
		LSU_RESP,
		LSU_WB
	} lsu_state_t;

endpackage

`default_nettype wire

// ==== src/axi_pkg.sv ====
// AXI4-Lite subset for single-beat word transfers; the map holds one SRAM window only
`default_nettype none

package axi_pkg;

	// response codes returned by the slave
	typedef logic [1:0] axi_resp_t;
	localparam axi_resp_t RESP_OKAY   = 2'd0;
	localparam axi_resp_t RESP_DECERR = 2'd3;

	// log2 of the bytes in one beat
	typedef logic [2:0] axi_size_t;
	localparam axi_size_t AXI_SIZE_4 = 3'd2;

	// SRAM window, 1 KiB of word storage
	localparam logic [31:0] SRAM_BASE_ADDR = 32'h8000_0000;
	localparam int SRAM_WORDS = 256;
	localparam int SRAM_IDX_W = $clog2(SRAM_WORDS);
	localparam logic [31:0] SRAM_LIMIT_ADDR = SRAM_BASE_ADDR + 32'(SRAM_WORDS * 4) - 32'd1;

endpackage

`default_nettype wire

// ==== src/lsu_store_align.sv ====
// combinational; byte-lane shifting only inside the SRAM window, other stores go out as given
`timescale 1ns/10ps
`default_nettype none

module lsu_store_align (
	input  wire lsu_pkg::store_type_t store_type_i,
	input  wire lsu_pkg::offset_t     offset_i,
	input  wire                       aligned_i,
	input  wire lsu_pkg::data_t       wdata_i,
	output lsu_pkg::strb_t            strb_o,
	output lsu_pkg::data_t            data_o
);
	import lsu_pkg::*;

	strb_t base_strb;

	// lanes the store covers before any offset
	always_comb begin
		case (store_type_i)
			STORE_NONE: begin
				base_strb = '0;
			end
			STORE_SB: begin
				base_strb = 4'b0001;
			end
			STORE_SH: begin
				base_strb = 4'b0011;
			end
			STORE_SW: begin
				base_strb = 4'b1111;
			end
			default: begin
				base_strb = '0;
			end
		endcase
	end

	// move to the addressed lane
	// anything pushed past byte 3 is dropped
	always_comb begin
		if (aligned_i) begin
			strb_o = base_strb << offset_i;
			data_o = wdata_i << (BYTE_W * offset_i);
		end else begin
			strb_o = base_strb;
			data_o = wdata_i;
		end
	end

endmodule

`default_nettype wire

// ==== src/lsu_load_extend.sv ====
// combinational; offset is only honoured inside the SRAM window, unknown load codes return the word
`timescale 1ns/10ps
`default_nettype none

module lsu_load_extend (
	input  wire lsu_pkg::load_type_t load_type_i,
	input  wire lsu_pkg::offset_t    offset_i,
	input  wire                      aligned_i,
	input  wire lsu_pkg::data_t      rdata_i,
	output lsu_pkg::data_t           value_o
);
	import lsu_pkg::*;

	data_t shifted;

	// bring the addressed byte down to lane 0
	always_comb begin
		if (aligned_i) begin
			shifted = rdata_i >> (BYTE_W * offset_i);
		end else begin
			shifted = rdata_i;
		end
	end

	always_comb begin
		case (load_type_i)
			LOAD_LB: begin
				value_o = {{(DATA_W - BYTE_W){shifted[BYTE_W-1]}}, shifted[BYTE_W-1:0]};
			end
			LOAD_LH: begin
				value_o = {{(DATA_W - HALF_W){shifted[HALF_W-1]}}, shifted[HALF_W-1:0]};
			end
			LOAD_LBU: begin
				value_o = {{(DATA_W - BYTE_W){1'b0}}, shifted[BYTE_W-1:0]};
			end
			LOAD_LHU: begin
				value_o = {{(DATA_W - HALF_W){1'b0}}, shifted[HALF_W-1:0]};
			end
			LOAD_LW: begin
				value_o = shifted;
			end
			default: begin
				value_o = shifted;
			end
		endcase
	end

endmodule

`default_nettype wire

// ==== src/lsu_ctrl.sv ====
// one access in flight; operands must stay steady from start_i until valid_o, loads win over stores
`timescale 1ns/10ps
`default_nettype none

module lsu_ctrl (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         start_i,
	input  wire lsu_pkg::load_type_t    load_type_i,
	input  wire lsu_pkg::store_type_t   store_type_i,
	input  wire lsu_pkg::addr_t         addr_i,
	input  wire lsu_pkg::data_t         wdata_i,
	// read address and data
	output lsu_pkg::addr_t              ar_addr_o,
	output logic                        ar_valid_o,
	output axi_pkg::axi_size_t          ar_size_o,
	input  wire                         ar_ready_i,
	input  wire lsu_pkg::data_t         r_data_i,
	input  wire axi_pkg::axi_resp_t     r_resp_i,
	input  wire                         r_valid_i,
	output logic                        r_ready_o,
	// write address, data and response
	output lsu_pkg::addr_t              aw_addr_o,
	output logic                        aw_valid_o,
	output axi_pkg::axi_size_t          aw_size_o,
	input  wire                         aw_ready_i,
	output lsu_pkg::data_t              w_data_o,
	output lsu_pkg::strb_t              w_strb_o,
	output logic                        w_valid_o,
	input  wire                         w_ready_i,
	input  wire axi_pkg::axi_resp_t     b_resp_i,
	input  wire                         b_valid_i,
	output logic                        b_ready_o,
	// aligners
	input  wire lsu_pkg::strb_t         st_strb_i,
	input  wire lsu_pkg::data_t         st_data_i,
	input  wire lsu_pkg::data_t         ld_value_i,
	output lsu_pkg::offset_t            offset_o,
	output logic                        aligned_o,
	// back to the core
	output lsu_pkg::data_t              result_o,
	output logic                        valid_o,
	output logic                        busy_o,
	output logic                        err_o
);
	import lsu_pkg::*;
	import axi_pkg::*;

	lsu_state_t con_state;
	lsu_state_t next_state;
	logic is_load;
	logic is_store;
	logic in_sram;
	logic addr_done;
	logic resp_done;
	offset_t offset_q;
	logic in_sram_q;
	data_t result_q;
	logic err_q;

	assign is_load = (load_type_i != LOAD_NONE);
	assign is_store = !is_load && (store_type_i != STORE_NONE);
	assign in_sram = (addr_i >= SRAM_BASE_ADDR) && (addr_i <= SRAM_LIMIT_ADDR);

	// channel drivers, AW and W always raised together
	assign ar_valid_o = (con_state == LSU_ADDR) && is_load;
	assign aw_valid_o = (con_state == LSU_ADDR) && is_store;
	assign w_valid_o = aw_valid_o;
	assign r_ready_o = (con_state == LSU_RESP) && is_load;
	assign b_ready_o = (con_state == LSU_RESP) && is_store;
	assign ar_addr_o = addr_i;
	assign aw_addr_o = addr_i;
	assign ar_size_o = AXI_SIZE_4;
	assign aw_size_o = AXI_SIZE_4;
	assign w_strb_o = st_strb_i;
	// device windows take the word exactly as the core gave it
	assign w_data_o = aligned_o ? st_data_i : wdata_i;

	assign addr_done = (ar_valid_o && ar_ready_i) ||
		(aw_valid_o && aw_ready_i && w_valid_o && w_ready_i);
	assign resp_done = (r_valid_i && r_ready_o) || (b_valid_i && b_ready_o);

	// live address during the address phase, captured copy for the response
	assign offset_o = (con_state == LSU_ADDR) ? addr_i[1:0] : offset_q;
	assign aligned_o = (con_state == LSU_ADDR) ? in_sram : in_sram_q;

	always_comb begin
		next_state = con_state;
		case (con_state)
			LSU_IDLE: begin
				if (start_i) begin
					next_state = LSU_ADDR;
				end
			end
			LSU_ADDR: begin
				// no memory access means straight to write-back
				if (!is_load && !is_store) begin
					next_state = LSU_WB;
				end else if (addr_done) begin
					next_state = LSU_RESP;
				end
			end
			LSU_RESP: begin
				if (resp_done) begin
					next_state = LSU_WB;
				end
			end
			default: begin
				next_state = LSU_IDLE;
			end
		endcase
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			con_state <= LSU_IDLE;
			err_q <= 1'b0;
		end else begin
			con_state <= next_state;
			// error flag lives only for the write-back cycle
			if (con_state == LSU_WB) begin
				err_q <= 1'b0;
			end else if (r_valid_i && r_ready_o) begin
				err_q <= (r_resp_i != RESP_OKAY);
			end else if (b_valid_i && b_ready_o) begin
				err_q <= (b_resp_i != RESP_OKAY);
			end
		end
	end

	always_ff @(posedge clock) begin
		if (con_state == LSU_ADDR) begin
			offset_q <= addr_i[1:0];
			in_sram_q <= in_sram;
		end
		if ((con_state == LSU_ADDR) && !is_load && !is_store) begin
			result_q <= addr_i;
		end else if (r_valid_i && r_ready_o) begin
			result_q <= ld_value_i;
		end else if (b_valid_i && b_ready_o) begin
			result_q <= '0;
		end
	end

	assign result_o = result_q;
	assign valid_o = (con_state == LSU_WB);
	assign busy_o = (con_state != LSU_IDLE);
	assign err_o = err_q;

endmodule

`default_nettype wire

// ==== src/axi_sram_slave.sv ====
// single-beat AXI4-Lite SRAM model; only one read and one write at a time, non-word sizes get DECERR
`timescale 1ns/10ps
`default_nettype none

module axi_sram_slave (
	input  wire                       clock,
	input  wire                       rstn,
	input  wire lsu_pkg::addr_t       ar_addr_i,
	input  wire                       ar_valid_i,
	input  wire axi_pkg::axi_size_t   ar_size_i,
	output logic                      ar_ready_o,
	output lsu_pkg::data_t            r_data_o,
	output axi_pkg::axi_resp_t        r_resp_o,
	output logic                      r_valid_o,
	input  wire                       r_ready_i,
	input  wire lsu_pkg::addr_t       aw_addr_i,
	input  wire                       aw_valid_i,
	input  wire axi_pkg::axi_size_t   aw_size_i,
	output logic                      aw_ready_o,
	input  wire lsu_pkg::data_t       w_data_i,
	input  wire lsu_pkg::strb_t       w_strb_i,
	input  wire                       w_valid_i,
	output logic                      w_ready_o,
	output axi_pkg::axi_resp_t        b_resp_o,
	output logic                      b_valid_o,
	input  wire                       b_ready_i
);
	import lsu_pkg::*;
	import axi_pkg::*;

	data_t mem [SRAM_WORDS];
	logic [3:0] lfsr;
	logic [1:0] rd_cnt;
	logic [1:0] rd_dly;
	logic rd_busy;
	logic [1:0] wr_cnt;
	logic [1:0] wr_dly;
	logic wr_busy;
	logic rd_hit;
	logic wr_hit;
	logic ar_done;
	logic r_done;
	logic aw_done;
	logic b_done;

	assign rd_hit = (ar_addr_i >= SRAM_BASE_ADDR) && (ar_addr_i <= SRAM_LIMIT_ADDR) &&
		(ar_size_i == AXI_SIZE_4);
	assign wr_hit = (aw_addr_i >= SRAM_BASE_ADDR) && (aw_addr_i <= SRAM_LIMIT_ADDR) &&
		(aw_size_i == AXI_SIZE_4);

	// ready or valid shows once the counter reaches the drawn delay
	assign ar_ready_o = ar_valid_i && !rd_busy && (rd_cnt == rd_dly);
	assign r_valid_o = rd_busy && (rd_cnt == rd_dly);
	// AW and W only accepted as a pair
	assign aw_ready_o = aw_valid_i && w_valid_i && !wr_busy && (wr_cnt == wr_dly);
	assign w_ready_o = aw_ready_o;
	assign b_valid_o = wr_busy && (wr_cnt == wr_dly);

	assign ar_done = ar_valid_i && ar_ready_o;
	assign r_done = r_valid_o && r_ready_i;
	assign aw_done = aw_valid_i && aw_ready_o;
	assign b_done = b_valid_o && b_ready_i;

	// x^4 + x^3 + 1, low bits pace reads and high bits pace writes
	always_ff @(posedge clock) begin
		if (!rstn) begin
			lfsr <= 4'b0001;
		end else begin
			lfsr <= {lfsr[2:0], lfsr[3] ^ lfsr[2]};
		end
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			rd_busy <= 1'b0;
			rd_cnt <= '0;
			rd_dly <= '0;
		end else if (ar_done || r_done) begin
			rd_busy <= ar_done;
			rd_cnt <= '0;
			rd_dly <= lfsr[1:0];
		end else if ((rd_busy || ar_valid_i) && (rd_cnt != rd_dly)) begin
			rd_cnt <= rd_cnt + 2'd1;
		end
	end

	always_ff @(posedge clock) begin
		if (!rstn) begin
			wr_busy <= 1'b0;
			wr_cnt <= '0;
			wr_dly <= '0;
		end else if (aw_done || b_done) begin
			wr_busy <= aw_done;
			wr_cnt <= '0;
			wr_dly <= lfsr[3:2];
		end else if ((wr_busy || (aw_valid_i && w_valid_i)) && (wr_cnt != wr_dly)) begin
			wr_cnt <= wr_cnt + 2'd1;
		end
	end

	// read word taken at the AR handshake, zero when off the map
	always_ff @(posedge clock) begin
		if (ar_done) begin
			r_data_o <= rd_hit ? mem[ar_addr_i[SRAM_IDX_W+1:2]] : '0;
			r_resp_o <= rd_hit ? RESP_OKAY : RESP_DECERR;
		end
	end

	always_ff @(posedge clock) begin
		if (aw_done && wr_hit) begin
			for (int b = 0; b < STRB_W; b++) begin
				if (w_strb_i[b]) begin
					mem[aw_addr_i[SRAM_IDX_W+1:2]][b*BYTE_W +: BYTE_W] <=
						w_data_i[b*BYTE_W +: BYTE_W];
				end
			end
		end
		if (aw_done) begin
			b_resp_o <= wr_hit ? RESP_OKAY : RESP_DECERR;
		end
	end

endmodule

`default_nettype wire

// ==== src/lsu_mem.sv ====
// LSU with its own SRAM slave; start_i only while busy_o is low, operands held until valid_o
`timescale 1ns/10ps
`default_nettype none

module lsu_mem (
	input  wire                         clock,
	input  wire                         rstn,
	input  wire                         start_i,
	input  wire lsu_pkg::load_type_t    load_type_i,
	input  wire lsu_pkg::store_type_t   store_type_i,
	input  wire lsu_pkg::addr_t         addr_i,
	input  wire lsu_pkg::data_t         wdata_i,
	input  wire lsu_pkg::reg_idx_t      rd_i,
	input  wire                         rd_wen_i,
	output lsu_pkg::data_t              result_o,
	output lsu_pkg::reg_idx_t           rd_o,
	output logic                        rd_wen_o,
	output logic                        valid_o,
	output logic                        busy_o,
	output logic                        err_o
);
	import lsu_pkg::*;
	import axi_pkg::*;

	addr_t ar_addr;
	logic ar_valid;
	axi_size_t ar_size;
	logic ar_ready;
	data_t r_data;
	axi_resp_t r_resp;
	logic r_valid;
	logic r_ready;
	addr_t aw_addr;
	logic aw_valid;
	axi_size_t aw_size;
	logic aw_ready;
	data_t w_data;
	strb_t w_strb;
	logic w_valid;
	logic w_ready;
	axi_resp_t b_resp;
	logic b_valid;
	logic b_ready;
	strb_t st_strb;
	data_t st_data;
	data_t ld_value;
	offset_t offset;
	logic aligned;

	lsu_ctrl u_ctrl (
		.clock(clock), .rstn(rstn), .start_i(start_i),
		.load_type_i(load_type_i), .store_type_i(store_type_i),
		.addr_i(addr_i), .wdata_i(wdata_i),
		.ar_addr_o(ar_addr), .ar_valid_o(ar_valid), .ar_size_o(ar_size),
		.ar_ready_i(ar_ready),
		.r_data_i(r_data), .r_resp_i(r_resp), .r_valid_i(r_valid), .r_ready_o(r_ready),
		.aw_addr_o(aw_addr), .aw_valid_o(aw_valid), .aw_size_o(aw_size),
		.aw_ready_i(aw_ready),
		.w_data_o(w_data), .w_strb_o(w_strb), .w_valid_o(w_valid), .w_ready_i(w_ready),
		.b_resp_i(b_resp), .b_valid_i(b_valid), .b_ready_o(b_ready),
		.st_strb_i(st_strb), .st_data_i(st_data), .ld_value_i(ld_value),
		.offset_o(offset), .aligned_o(aligned),
		.result_o(result_o), .valid_o(valid_o), .busy_o(busy_o), .err_o(err_o)
	);

	lsu_store_align u_store_align (
		.store_type_i(store_type_i), .offset_i(offset), .aligned_i(aligned),
		.wdata_i(wdata_i), .strb_o(st_strb), .data_o(st_data)
	);

	lsu_load_extend u_load_extend (
		.load_type_i(load_type_i), .offset_i(offset), .aligned_i(aligned),
		.rdata_i(r_data), .value_o(ld_value)
	);

	axi_sram_slave u_sram (
		.clock(clock), .rstn(rstn),
		.ar_addr_i(ar_addr), .ar_valid_i(ar_valid), .ar_size_i(ar_size),
		.ar_ready_o(ar_ready),
		.r_data_o(r_data), .r_resp_o(r_resp), .r_valid_o(r_valid), .r_ready_i(r_ready),
		.aw_addr_i(aw_addr), .aw_valid_i(aw_valid), .aw_size_i(aw_size),
		.aw_ready_o(aw_ready),
		.w_data_i(w_data), .w_strb_i(w_strb), .w_valid_i(w_valid), .w_ready_o(w_ready),
		.b_resp_o(b_resp), .b_valid_o(b_valid), .b_ready_i(b_ready)
	);

	// destination register travels alongside the access
	assign rd_o = rd_i;
	assign rd_wen_o = rd_wen_i;

endmodule

`default_nettype wire

// ==== test/clock_gen.sv ====
// free-running 8 ns clock; reset is held low over the first two rising edges only
`timescale 1ns/10ps
`default_nettype none

module clock_gen (
	output logic clock_o,
	output logic rstn_o
);
	localparam int HALF_PERIOD = 4;

	initial begin
		clock_o = 1'b0;
		forever begin
			#HALF_PERIOD clock_o = ~clock_o;
		end
	end

	// release on a falling edge, away from the sampling edge
	initial begin
		rstn_o = 1'b0;
		repeat (2) begin
			@(posedge clock_o);
		end
		@(negedge clock_o);
		rstn_o = 1'b1;
	end

endmodule

`default_nettype wire

// ==== test/tb_lsu_mem.sv ====
// one access at a time through lsu_mem; expected values come from a byte image of the SRAM
`timescale 1ns/10ps
`default_nettype none

module tb_lsu_mem;
	import lsu_pkg::*;
	import axi_pkg::*;

	localparam int NUM_ROWS = 36;
	localparam int TIMEOUT_CYCLES = NUM_ROWS * 20 + 50;

	logic clock;
	logic rstn;
	logic start;
	load_type_t load_type;
	store_type_t store_type;
	addr_t addr;
	data_t wdata;
	reg_idx_t rd;
	logic rd_wen;
	data_t result;
	reg_idx_t rd_out;
	logic rd_wen_out;
	logic valid;
	logic busy;
	logic err;

	// stimulus table, one entry per access
	string row_name [NUM_ROWS];
	load_type_t row_ld [NUM_ROWS];
	store_type_t row_st [NUM_ROWS];
	addr_t row_addr [NUM_ROWS];
	data_t row_wdata [NUM_ROWS];
	logic row_err [NUM_ROWS];
	int num_rows;

	// byte image of the SRAM
	logic [7:0] ref_mem [SRAM_WORDS * 4];
	int seed;
	int fail_cnt;
	int cycle_cnt;

	clock_gen clock_gen_inst (.clock_o(clock), .rstn_o(rstn));

	lsu_mem lsu_mem_inst (
		.clock(clock), .rstn(rstn), .start_i(start),
		.load_type_i(load_type), .store_type_i(store_type),
		.addr_i(addr), .wdata_i(wdata), .rd_i(rd), .rd_wen_i(rd_wen),
		.result_o(result), .rd_o(rd_out), .rd_wen_o(rd_wen_out),
		.valid_o(valid), .busy_o(busy), .err_o(err)
	);

	task automatic add_row(input string name, input load_type_t ld, input store_type_t st,
		input addr_t a, input data_t d, input logic e);
		row_name[num_rows] = name;
		row_ld[num_rows] = ld;
		row_st[num_rows] = st;
		row_addr[num_rows] = a;
		row_wdata[num_rows] = d;
		row_err[num_rows] = e;
		num_rows++;
	endtask

	task automatic build_table();
		addr_t word_addr;
		addr_t rnd_addr;
		addr_t ext_addr;
		word_addr = SRAM_BASE_ADDR + 32'h10;
		rnd_addr = SRAM_BASE_ADDR | (addr_t'($random(seed)) & 32'h0000_03fc);
		ext_addr = SRAM_BASE_ADDR + 32'h20;
		add_row("sw_word", LOAD_NONE, STORE_SW, word_addr, data_t'($random(seed)), 1'b0);
		add_row("lw_word", LOAD_LW, STORE_NONE, word_addr, '0, 1'b0);
		add_row("sw_rand", LOAD_NONE, STORE_SW, rnd_addr, data_t'($random(seed)), 1'b0);
		add_row("lw_rand", LOAD_LW, STORE_NONE, rnd_addr, '0, 1'b0);
		// partial stores into an already written word
		add_row("sb_off1", LOAD_NONE, STORE_SB, word_addr + 32'd1, data_t'($random(seed)), 1'b0);
		add_row("sh_off2", LOAD_NONE, STORE_SH, word_addr + 32'd2, data_t'($random(seed)), 1'b0);
		add_row("sb_off3", LOAD_NONE, STORE_SB, word_addr + 32'd3, data_t'($random(seed)), 1'b0);
		add_row("lw_after_sb", LOAD_LW, STORE_NONE, word_addr, '0, 1'b0);
		add_row("sh_off1", LOAD_NONE, STORE_SH, word_addr + 32'd1, data_t'($random(seed)), 1'b0);
		add_row("sh_off3", LOAD_NONE, STORE_SH, word_addr + 32'd3, data_t'($random(seed)), 1'b0);
		add_row("lw_after_sh", LOAD_LW, STORE_NONE, word_addr, '0, 1'b0);
		add_row("sb_off2", LOAD_NONE, STORE_SB, rnd_addr + 32'd2, data_t'($random(seed)), 1'b0);
		add_row("lw_after_sb2", LOAD_LW, STORE_NONE, rnd_addr, '0, 1'b0);
		// bytes and halves of both signs
		add_row("sw_ext", LOAD_NONE, STORE_SW, ext_addr, 32'h80ff_7f01, 1'b0);
		for (int o = 0; o < 4; o++) begin
			add_row($sformatf("lb_off%0d", o), LOAD_LB, STORE_NONE,
				ext_addr + addr_t'(o), '0, 1'b0);
			add_row($sformatf("lbu_off%0d", o), LOAD_LBU, STORE_NONE,
				ext_addr + addr_t'(o), '0, 1'b0);
			add_row($sformatf("lh_off%0d", o), LOAD_LH, STORE_NONE,
				ext_addr + addr_t'(o), '0, 1'b0);
			add_row($sformatf("lhu_off%0d", o), LOAD_LHU, STORE_NONE,
				ext_addr + addr_t'(o), '0, 1'b0);
		end
		// off the map, DECERR expected
		add_row("sw_decerr", LOAD_NONE, STORE_SW, 32'h0000_1000, 32'hdead_beef, 1'b1);
		add_row("lw_decerr", LOAD_LW, STORE_NONE, 32'h0000_1000, '0, 1'b1);
		add_row("lb_decerr", LOAD_LB, STORE_NONE, 32'h0000_1003, '0, 1'b1);
		add_row("lh_past_end", LOAD_LH, STORE_NONE, SRAM_LIMIT_ADDR + 32'd3, '0, 1'b1);
		add_row("nop_fixed", LOAD_NONE, STORE_NONE, 32'h1234_5678, '0, 1'b0);
		add_row("nop_rand", LOAD_NONE, STORE_NONE, addr_t'($random(seed)), '0, 1'b0);
	endtask

	// expected result of one access, stores update the byte image
	function automatic data_t model_access(input load_type_t ld, input store_type_t st,
		input addr_t a, input data_t d);
		int o;
		int byte_base;
		strb_t strb;
		data_t word;
		o = int'(a[1:0]);
		byte_base = int'(a[9:2]) * 4;
		if (ld == LOAD_NONE && st == STORE_NONE) begin
			return a;
		end
		if (a < SRAM_BASE_ADDR || a > SRAM_LIMIT_ADDR) begin
			return '0;
		end
		if (ld != LOAD_NONE) begin
			word = {ref_mem[byte_base + 3], ref_mem[byte_base + 2],
				ref_mem[byte_base + 1], ref_mem[byte_base]};
			word = word >> (8 * o);
			case (ld)
				LOAD_LB: return {{24{word[7]}}, word[7:0]};
				LOAD_LH: return {{16{word[15]}}, word[15:0]};
				LOAD_LBU: return {24'd0, word[7:0]};
				LOAD_LHU: return {16'd0, word[15:0]};
				default: return word;
			endcase
		end
		strb = (st == STORE_SB) ? 4'b0001 : ((st == STORE_SH) ? 4'b0011 : 4'b1111);
		// lanes pushed past byte 3 are lost
		for (int b = 0; b < 4; b++) begin
			if ((b >= o) && strb[b - o]) begin
				ref_mem[byte_base + b] = d[8 * (b - o) +: 8];
			end
		end
		return '0;
	endfunction

	task automatic run_row(input int idx);
		data_t exp_val;
		reg_idx_t exp_rd;
		logic exp_rd_wen;
		int cycles;
		logic row_ok;
		row_ok = 1'b1;
		exp_val = model_access(row_ld[idx], row_st[idx], row_addr[idx], row_wdata[idx]);
		exp_rd = 5'($random(seed));
		exp_rd_wen = 1'($random(seed));
		load_type = row_ld[idx];
		store_type = row_st[idx];
		addr = row_addr[idx];
		wdata = row_wdata[idx];
		rd = exp_rd;
		rd_wen = exp_rd_wen;
		start = 1'b1;
		@(negedge clock);
		start = 1'b0;
		cycles = 1;
		while (!valid) begin
			if (!busy) begin
				$display("%s: busy_o went low before valid_o", row_name[idx]);
				row_ok = 1'b0;
			end
			@(negedge clock);
			cycles++;
		end
		if (result !== exp_val) begin
			$display("FAIL %s result expected %h actual %h", row_name[idx], exp_val, result);
			row_ok = 1'b0;
		end
		if (err !== row_err[idx]) begin
			$display("FAIL %s err_o expected %b actual %b", row_name[idx], row_err[idx], err);
			row_ok = 1'b0;
		end
		if (rd_out !== exp_rd || rd_wen_out !== exp_rd_wen) begin
			$display("FAIL %s rd_o/rd_wen_o expected %h/%b actual %h/%b", row_name[idx],
				exp_rd, exp_rd_wen, rd_out, rd_wen_out);
			row_ok = 1'b0;
		end
		if (!busy) begin
			$display("%s: busy_o was low in the valid_o cycle", row_name[idx]);
			row_ok = 1'b0;
		end
		if (row_ld[idx] == LOAD_NONE && row_st[idx] == STORE_NONE && cycles != 2) begin
			$display("%s: valid_o came %0d cycles after start_i instead of 2",
				row_name[idx], cycles);
			row_ok = 1'b0;
		end
		@(negedge clock);
		if (valid || busy) begin
			$display("%s: valid_o or busy_o still high after the access", row_name[idx]);
			row_ok = 1'b0;
		end
		load_type = LOAD_NONE;
		store_type = STORE_NONE;
		if (row_ok) begin
			$display("test %0d %s: ok", idx, row_name[idx]);
		end else begin
			$display("test %0d %s: mismatch", idx, row_name[idx]);
			fail_cnt++;
		end
	endtask

	// watchdog on the whole run
	initial begin
		cycle_cnt = 0;
		while (cycle_cnt < TIMEOUT_CYCLES) begin
			@(posedge clock);
			cycle_cnt++;
		end
		$display("timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("CHECKS FAILED");
		$finish;
	end

	initial begin
		start = 1'b0;
		load_type = LOAD_NONE;
		store_type = STORE_NONE;
		addr = '0;
		wdata = '0;
		rd = '0;
		rd_wen = 1'b0;
		seed = 32'h9f16_9513;
		fail_cnt = 0;
		num_rows = 0;
		for (int i = 0; i < SRAM_WORDS * 4; i++) begin
			ref_mem[i] = 8'h00;
		end
		build_table();
		wait (rstn === 1'b1);
		@(negedge clock);
		if (valid !== 1'b0 || busy !== 1'b0 || err !== 1'b0) begin
			$display("reset: valid_o, busy_o or err_o not low after reset");
			fail_cnt++;
		end else begin
			$display("reset: ok");
		end
		for (int i = 0; i < num_rows; i++) begin
			run_row(i);
		end
		$display("tests %0d, passed %0d, failed %0d", num_rows + 1,
			num_rows + 1 - fail_cnt, fail_cnt);
		if (fail_cnt == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

endmodule

`default_nettype wire

// ==== lsu_mem.f ====
src/lsu_pkg.sv
src/axi_pkg.sv
src/lsu_store_align.sv
src/lsu_load_extend.sv
src/lsu_ctrl.sv
src/axi_sram_slave.sv
src/lsu_mem.sv
test/clock_gen.sv
test/tb_lsu_mem.sv

// ==== Makefile ====
SIM      ?= verilator
FLAGS    ?= --binary --timing --timescale 1ns/10ps -j 0
TOP      ?= tb_lsu_mem
FILELIST ?= lsu_mem.f
BUILD    ?= obj_dir
LOG      ?= sim.log
PASS_MSG := ALL CHECKS PASSED

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build $(TOP) with $(SIM), run it and search $(LOG) for the pass message"
	@echo "  clean  remove $(BUILD) and $(LOG)"
	@echo "  help   show this list"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD) -o V$(TOP)
	./$(BUILD)/V$(TOP) | tee $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) || (echo "simulation did not pass, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD) $(LOG)
